// ==== Makefile ====
TOP = tb_uart_upper_echo

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f list.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "sim passed"

lint:
	verilator --lint-only -Wall --top-module uart_upper_echo \
		source/uart_echo_pkg.sv source/uart_rx.sv source/uart_tx.sv \
		source/greeting_sender.sv source/uart_upper_echo.sv

clean:
	rm -rf obj_dir

// ==== bench/serial_line_model.sv ====
`timescale 1ns/1ns

module serial_line_model
  import uart_echo_pkg::*;
(
  input  logic clk,
  output logic urx_pin,
  input  logic utx_pin
);

  // bytes decoded from the DUT transmit line, oldest first
  byte_t rx_queue[$];
  int    rx_count;
  int    stop_errors;

  initial begin
    urx_pin     = 1'b1;
    rx_count    = 0;
    stop_errors = 0;
  end

  // called on a falling clock edge, returns on the falling edge that ends
  // the stop bit with the line idle again
  task automatic send_byte(input byte_t data, input logic stop_bit);
    byte_t bits;
    bits    = data;
    urx_pin = 1'b0;
    repeat (CLKS_PER_BIT) @(negedge clk);
    repeat (8) begin
      urx_pin = bits[0];
      bits    = bits >> 1;
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
    urx_pin = stop_bit;
    repeat (CLKS_PER_BIT) @(negedge clk);
    urx_pin = 1'b1;
  endtask

  // the DUT moves utx_pin on rising edges, so the decoder looks at it on
  // falling edges only
  always begin : decoder
    byte_t data;
    @(negedge clk);
    if (utx_pin == 1'b0) begin
      // half a clock into the start bit already, step on to its middle
      repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
      repeat (8) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data = {utx_pin, data[7:1]};
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (utx_pin == 1'b1) begin
        rx_queue.push_back(data);
        rx_count = rx_count + 1;
      end else begin
        stop_errors = stop_errors + 1;
      end
    end
  end

endmodule

// ==== bench/tb_uart_upper_echo.sv ====
`timescale 1ns/1ns

module tb_uart_upper_echo
  import uart_echo_pkg::*;
;

  localparam int RANDOM_COUNT   = 40;
  localparam int BURST_COUNT    = 8;
  localparam int BOUNDARY_COUNT = 6;
  // the two frames of the stop bit test count as sent, even the bad one
  localparam int SENT_COUNT     = RANDOM_COUNT + BURST_COUNT + BOUNDARY_COUNT + 2;
  localparam int WATCHDOG_NS    = (GREETING_LEN + SENT_COUNT) * 10 * CLKS_PER_BIT * 20 * 3;

  logic clk;
  logic rst_n;
  logic urx_pin;
  logic utx_pin;

  logic [31:0] lfsr_state;
  // bytes the DUT should put on utx_pin, in order
  byte_t       exp_q[$];
  int          checked;

  uart_upper_echo uart_upper_echo_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .urx_pin(urx_pin),
    .utx_pin(utx_pin)
  );

  serial_line_model line_model_inst (
    .clk    (clk),
    .urx_pin(urx_pin),
    .utx_pin(utx_pin)
  );

  always #10 clk = ~clk;

  // taps 32, 22, 2 and 1, one step for every bit handed out
  function automatic logic [31:0] next_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  // a lower-case letter differs from its upper-case form only in bit 5
  function automatic byte_t upper_case_of(input byte_t b);
    if (b inside {[8'h61:8'h7a]}) begin
      return {b[7:6], 1'b0, b[4:0]};
    end
    return b;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_pin(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s: got %0h, expected %0h", what, got, exp));
    end
  endtask

  task automatic check_byte(input string what, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s: got %02h, expected %02h", what, got, exp));
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("CHECK FAILED %s: got %0h, expected %0h", what, got, exp));
    end
  endtask

  // waits until the decoder has as many bytes as expected, then compares
  // the ones not yet looked at
  task automatic check_echoes();
    while (line_model_inst.rx_count < exp_q.size()) begin
      @(negedge clk);
    end
    for (int i = checked; i < exp_q.size(); i++) begin
      check_byte($sformatf("utx_pin byte %0d", i), line_model_inst.rx_queue[i], exp_q[i]);
    end
    checked = exp_q.size();
  endtask

  task automatic send_echo(input byte_t data, input int gap);
    line_model_inst.send_byte(data, 1'b1);
    exp_q.push_back(upper_case_of(data));
    repeat (gap) @(negedge clk);
  endtask

  // expected value given directly, so the model's conversion is checked too
  task automatic send_boundary(input byte_t data, input byte_t echo);
    line_model_inst.send_byte(data, 1'b1);
    exp_q.push_back(echo);
    repeat (CLKS_PER_BIT) @(negedge clk);
  endtask

  initial begin : stimulus
    logic [8*GREETING_LEN-1:0] text;
    logic [31:0]               rnd;
    byte_t                     data;
    int                        gap;

    clk        = 1'b0;
    rst_n      = 1'b0;
    lfsr_state = 32'hd60c;
    checked    = 0;

    repeat (2) begin
      @(negedge clk);
      check_pin("utx_pin during reset", utx_pin, 1'b1);
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_pin("utx_pin after reset", utx_pin, 1'b1);

    // first character sits in the top byte of the greeting
    text = GREETING;
    repeat (GREETING_LEN) begin
      exp_q.push_back(text[8*GREETING_LEN-1 -: 8]);
      text = text << 8;
    end
    check_echoes();

    for (int n = 0; n < RANDOM_COUNT; n++) begin
      rnd  = next_bits(8);
      data = rnd[7:0];
      // half the bytes land in 40h to 7Fh so that letters turn up often
      if (next_bits(1) == 32'd1) begin
        data = {2'b01, data[5:0]};
      end
      rnd = next_bits(6);
      gap = CLKS_PER_BIT + int'(rnd[5:0]);
      send_echo(data, gap);
    end
    check_echoes();

    send_boundary(8'h60, 8'h60);
    send_boundary(8'h61, 8'h41);
    send_boundary(8'h7a, 8'h5a);
    send_boundary(8'h7b, 8'h7b);
    send_boundary(8'h41, 8'h41);
    send_boundary(8'h5a, 8'h5a);
    check_echoes();

    // no idle time at all between these frames
    for (int n = 0; n < BURST_COUNT; n++) begin
      rnd = next_bits(8);
      send_echo(rnd[7:0], 0);
    end
    check_echoes();

    // the receiver must drop the first frame and keep only the second
    line_model_inst.send_byte(8'h6b, 1'b0);
    repeat (CLKS_PER_BIT) @(negedge clk);
    send_echo(8'h71, CLKS_PER_BIT);
    check_echoes();

    // anything still coming out now would be an extra echo
    repeat (3 * 10 * CLKS_PER_BIT) @(negedge clk);
    check_count("utx_pin byte count", line_model_inst.rx_count, exp_q.size());
    check_count("utx_pin frames with low stop bit", line_model_inst.stop_errors, 0);

    $display("sim passed");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    fail_run($sformatf("timed out after %0d ns waiting for the DUT to echo", WATCHDOG_NS));
  end

endmodule

// ==== list.f ====
source/uart_echo_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/greeting_sender.sv
source/uart_upper_echo.sv
bench/serial_line_model.sv
bench/tb_uart_upper_echo.sv

// ==== source/greeting_sender.sv ====
`timescale 1ns/1ns

module greeting_sender
  import uart_echo_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  greet_start,
  output logic  chr_valid,
  output byte_t chr_data,
  input  logic  chr_ready,
  output logic  greet_done
);

  typedef logic [$clog2(GREETING_LEN)-1:0] greet_index_t;

  // counts down, since the first character is the top byte of GREETING
  greet_index_t idx;

  logic chr_fire;
  logic last_chr;

  assign chr_fire = chr_valid && chr_ready;
  assign last_chr = (idx == '0);

  assign chr_data = GREETING[idx];

  // high in the same cycle as the transfer of the final byte
  assign greet_done = chr_fire && last_chr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      chr_valid <= 1'b0;
      idx       <= '0;
    end else begin
      if (greet_start) begin
        chr_valid <= 1'b1;
        idx       <= greet_index_t'(GREETING_LEN - 1);
      end else if (chr_fire) begin
        if (last_chr) begin
          chr_valid <= 1'b0;
        end else begin
          idx <= idx - 1'b1;
        end
      end
    end
  end

  // restarting in the middle of the text would cut the greeting short
  assert property (@(posedge clk) disable iff (!rst_n) greet_start |-> !chr_valid);

endmodule

// ==== source/uart_echo_pkg.sv ====
package uart_echo_pkg;

  // one serial character as it travels on every internal byte stream
  typedef logic [7:0] byte_t;

  // clock cycles in one bit time on the serial line
  localparam int CLKS_PER_BIT = 16;

  // the baud counter has to reach CLKS_PER_BIT itself, not only CLKS_PER_BIT-1,
  // because the transmitter holds its stop bit one cycle longer before it is ready
  typedef logic [$clog2(CLKS_PER_BIT + 1)-1:0] baud_count_t;

  // position of a bit inside a frame, 0 to 7 for data
  typedef logic [3:0] bit_count_t;

  // greeting text plus CR and LF
  localparam int GREETING_LEN = 19;

  // first character sits in the most significant byte, so GREETING[GREETING_LEN-1]
  // goes out first and GREETING[0] (the LF) goes out last
  localparam byte_t [GREETING_LEN-1:0] GREETING = {
    "Hello - to upper:",
    8'h0d,
    8'h0a
  };

endpackage

// ==== source/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx
  import uart_echo_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  urx_pin,
  output logic  urx_valid,
  output byte_t urx_data,
  input  logic  urx_ready
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t   state;
  baud_count_t baud_cnt;
  bit_count_t  bit_cnt;
  byte_t       shift_reg;

  // two-flop synchronizer plus one more stage for the falling edge
  logic urx_meta;
  logic urx_sync;
  logic urx_prev;

  logic baud_half;
  logic baud_last;

  // the start bit is checked half a bit after the edge, which puts every
  // later sample in the middle of its bit
  assign baud_half = (baud_cnt == baud_count_t'(CLKS_PER_BIT / 2 - 1));
  assign baud_last = (baud_cnt == baud_count_t'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      urx_meta <= 1'b1;
      urx_sync <= 1'b1;
      urx_prev <= 1'b1;
    end else begin
      urx_meta <= urx_pin;
      urx_sync <= urx_meta;
      urx_prev <= urx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= RX_IDLE;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      urx_valid <= 1'b0;
    end else begin
      if (urx_valid && urx_ready) begin
        urx_valid <= 1'b0;
      end

      case (state)
        RX_IDLE: begin
          if (urx_prev && !urx_sync) begin
            baud_cnt <= '0;
            state    <= RX_START;
          end
        end

        RX_START: begin
          if (baud_half) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            // a glitch that is high again by mid-bit is not a start bit
            state    <= urx_sync ? RX_IDLE : RX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end

        RX_DATA: begin
          if (baud_last) begin
            baud_cnt  <= '0;
            shift_reg <= {urx_sync, shift_reg[7:1]};
            bit_cnt   <= bit_cnt + 1'b1;
            if (bit_cnt == bit_count_t'(7)) begin
              state <= RX_STOP;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end

        RX_STOP: begin
          if (baud_last) begin
            baud_cnt <= '0;
            state    <= RX_IDLE;
            // a low stop bit is a framing error and the byte is dropped
            if (urx_sync) begin
              urx_valid <= 1'b1;
              urx_data  <= shift_reg;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end

        default: state <= RX_IDLE;
      endcase
    end
  end

  // the top level relies on a pending byte staying put until it takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    urx_valid && !urx_ready |=> $stable(urx_data));

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx
  import uart_echo_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  utx_valid,
  input  byte_t utx_data,
  output logic  utx_ready,
  output logic  utx_pin
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  tx_state_t   state;
  baud_count_t baud_cnt;
  bit_count_t  bit_cnt;
  byte_t       shift_reg;

  logic baud_last;

  assign baud_last = (baud_cnt == baud_count_t'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= TX_IDLE;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      utx_ready <= 1'b1;
      utx_pin   <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          if (utx_valid && utx_ready) begin
            shift_reg <= utx_data;
            utx_ready <= 1'b0;
            utx_pin   <= 1'b0;
            baud_cnt  <= '0;
            state     <= TX_START;
          end
        end

        TX_START: begin
          if (baud_last) begin
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            utx_pin   <= shift_reg[0];
            shift_reg <= shift_reg >> 1;
            state     <= TX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end

        TX_DATA: begin
          if (baud_last) begin
            baud_cnt <= '0;
            if (bit_cnt == bit_count_t'(7)) begin
              utx_pin <= 1'b1;
              state   <= TX_STOP;
            end else begin
              bit_cnt   <= bit_cnt + 1'b1;
              utx_pin   <= shift_reg[0];
              shift_reg <= shift_reg >> 1;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end

        TX_STOP: begin
          // counts one cycle past the bit time, so ready comes back the
          // cycle after the stop bit has fully gone out
          if (baud_cnt == baud_count_t'(CLKS_PER_BIT)) begin
            utx_ready <= 1'b1;
            state     <= TX_IDLE;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end

        default: state <= TX_IDLE;
      endcase
    end
  end

  // a new frame may only start from an idle line
  assert property (@(posedge clk) disable iff (!rst_n) utx_ready |-> utx_pin);

endmodule

// ==== source/uart_upper_echo.sv ====
`timescale 1ns/1ns

module uart_upper_echo
  import uart_echo_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic urx_pin,
  output logic utx_pin
);

  typedef enum logic [1:0] {
    IDLE,
    GREET,
    GREET_WAIT,
    ECHO
  } echo_state_t;

  echo_state_t state;

  logic  urx_valid;
  byte_t urx_data;
  logic  urx_ready;

  logic  utx_valid;
  byte_t utx_data;
  logic  utx_ready;

  logic  chr_valid;
  byte_t chr_data;
  logic  chr_ready;

  logic  greet_start;
  logic  greet_done;

  // single entry between the receiver and the transmitter
  logic  echo_valid;
  byte_t echo_data;
  byte_t upper_data;

  uart_rx uart_rx_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .urx_pin  (urx_pin),
    .urx_valid(urx_valid),
    .urx_data (urx_data),
    .urx_ready(urx_ready)
  );

  uart_tx uart_tx_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .utx_valid(utx_valid),
    .utx_data (utx_data),
    .utx_ready(utx_ready),
    .utx_pin  (utx_pin)
  );

  greeting_sender greeting_sender_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .greet_start(greet_start),
    .chr_valid  (chr_valid),
    .chr_data   (chr_data),
    .chr_ready  (chr_ready),
    .greet_done (greet_done)
  );

  // 'a' through 'z' sit exactly 20h above 'A' through 'Z'
  assign upper_data = (urx_data >= 8'h61 && urx_data <= 8'h7a) ? urx_data - 8'h20 : urx_data;

  assign greet_start = (state == GREET);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= IDLE;
      echo_valid <= 1'b0;
    end else begin
      if (echo_valid && utx_ready) begin
        echo_valid <= 1'b0;
      end

      case (state)
        IDLE:       state <= GREET;
        GREET:      state <= GREET_WAIT;
        GREET_WAIT: begin
          if (greet_done) begin
            state <= ECHO;
          end
        end
        ECHO: begin
          // a new byte may land in the same cycle the old one leaves
          if (urx_valid && urx_ready) begin
            echo_valid <= 1'b1;
            echo_data  <= upper_data;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // only one source is ever active, the greeting before ECHO and the echo after
  assign chr_ready = utx_ready;
  assign utx_valid = chr_valid || echo_valid;
  assign utx_data  = (state == ECHO) ? echo_data : chr_data;
  assign urx_ready = (state == ECHO) && (!echo_valid || utx_ready);

  assert property (@(posedge clk) disable iff (!rst_n) !(chr_valid && echo_valid));

  // bytes arriving during the greeting stay in the receiver
  assert property (@(posedge clk) disable iff (!rst_n)
    state != ECHO && urx_valid |=> urx_valid);

endmodule
